// ==== rtl/sm83_pkg.sv ====
`default_nettype none

package sm83_pkg;

	// Internal data bus width
	localparam int WORD_SIZE = 8;

	// Opcode or data byte
	typedef logic [WORD_SIZE-1:0] word_t;

	// Register pair code as it appears in opcode fields
	typedef logic [1:0] reg_pair_t;

	localparam reg_pair_t REG_BC = 2'd0;
	localparam reg_pair_t REG_DE = 2'd1;
	localparam reg_pair_t REG_HL = 2'd2;
	localparam reg_pair_t REG_AF = 2'd3;

	// Four T-states per machine cycle
	typedef enum logic [1:0] {T1, T2, T3, T4} t_state_t;

	// Up to four machine cycles per instruction
	typedef enum logic [1:0] {M1, M2, M3, M4} m_cycle_t;

	typedef enum logic [3:0] {
		NOP,
		LD_R_N,      // LD r,n
		LD_HL_N,     // LD (HL),n
		LD_R_R,      // LD r,r'
		LD_R_HL,     // LD r,(HL)
		LD_HL_R,     // LD (HL),r
		ST_XX_A,     // LD (BC/DE),A
		LD_A_XX,     // LD A,(BC/DE)
		ST_NN_A,     // LDX (nn),A
		LD_A_NN,     // LDX A,(nn)
		UNSUPPORTED  // HALT and anything else, runs as a plain fetch
	} instr_class_t;

	typedef struct packed {
		instr_class_t cls;
		reg_pair_t    src_pair;  // Opcode bits 2:1
		logic         src_hi;
		reg_pair_t    dst_pair;  // Opcode bits 5:4
		logic         dst_hi;
		reg_pair_t    ind_pair;  // Pair used for (BC/DE) addressing
	} decode_t;

	typedef struct packed {
		logic mread;
		logic mwrite;
	} mem_ctl_t;

	// Register file strobes
	typedef struct packed {
		logic      hi_oe;
		logic      lo_oe;
		logic      adr_oe;
		logic      hi_in;
		logic      lo_in;
		logic      hi_we;
		logic      lo_we;
		reg_pair_t sel;
		logic      pc_oe;
		logic      pc_we;
	} reg_ctl_t;

	// Incrementer and address latch
	typedef struct packed {
		logic inc_oe;
		logic inc_carry;
		logic al_hi_we;
		logic al_lo_we;
	} adr_ctl_t;

	// Internal bus bridges, data latch and IR
	typedef struct packed {
		logic db_c2l_oe;
		logic db_l2c_oe;
		logic db_l2h_oe;
		logic db_h2l_oe;
		logic io_data_oe;
		logic io_data_we;
		logic zero_data_oe;
		logic ir_we;
		logic ir_bank_we;
	} bus_ctl_t;

	// ALU operand A path
	typedef struct packed {
		logic sh_oe;
		logic op_a_bus;
		logic op_a_oe;
		logic oe;
		logic cond_we;
	} alu_ctl_t;

endpackage

`default_nettype wire

// ==== rtl/sm83_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_sequencer (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               last_cycle,
	output sm83_pkg::m_cycle_t      m_cycle,
	output sm83_pkg::t_state_t      t_state
);

	always_ff @(posedge clk) begin
		if (reset) begin
			// Hold the start of an instruction
			m_cycle <= sm83_pkg::M1;
			t_state <= sm83_pkg::T1;
		end else begin
			// T-state steps every clock, T4 wraps to T1
			t_state <= sm83_pkg::t_state_t'(t_state + 2'd1);

			if (t_state == sm83_pkg::T4) begin
				if (last_cycle) begin
					// Instruction done, next fetch
					m_cycle <= sm83_pkg::M1;
				end else begin
					// Next machine cycle
					// M4 would wrap to M1 on its own
					m_cycle <= sm83_pkg::m_cycle_t'(m_cycle + 2'd1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sm83_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_decode (
	input  wire sm83_pkg::word_t    opcode,
	output sm83_pkg::decode_t       dec
);

	// High byte select for a 3-bit register field
	// B, D, H and A are high, C, E and L are low
	function automatic logic field_hi(input logic [2:0] field);
		return (field[2:1] == sm83_pkg::REG_AF) ? field[0] : ~field[0];
	endfunction

	always_comb begin
		// Register fields
		dec.src_pair = opcode[2:1];
		dec.src_hi   = field_hi(opcode[2:0]);
		dec.dst_pair = opcode[5:4];
		dec.dst_hi   = field_hi(opcode[5:3]);

		// BC or DE for the indirect A loads
		dec.ind_pair = opcode[5:4];

		// First matching pattern wins
		casez (opcode)
			8'h00: begin
				dec.cls = sm83_pkg::NOP;
			end
			// 00 110 110
			8'h36: begin
				dec.cls = sm83_pkg::LD_HL_N;
			end
			// 00 rrr 110
			8'b00??_?110: begin
				dec.cls = sm83_pkg::LD_R_N;
			end
			// HALT sits inside the LD block
			8'h76: begin
				dec.cls = sm83_pkg::UNSUPPORTED;
			end
			// 01 110 sss
			8'b0111_0???: begin
				dec.cls = sm83_pkg::LD_HL_R;
			end
			// 01 ddd 110
			8'b01??_?110: begin
				dec.cls = sm83_pkg::LD_R_HL;
			end
			// 01 ddd sss
			8'b01??_????: begin
				dec.cls = sm83_pkg::LD_R_R;
			end
			// 0x02 and 0x12
			8'b000?_0010: begin
				dec.cls = sm83_pkg::ST_XX_A;
			end
			// 0x0A and 0x1A
			8'b000?_1010: begin
				dec.cls = sm83_pkg::LD_A_XX;
			end
			8'hEA: begin
				dec.cls = sm83_pkg::ST_NN_A;
			end
			8'hFA: begin
				dec.cls = sm83_pkg::LD_A_NN;
			end
			default: begin
				dec.cls = sm83_pkg::UNSUPPORTED;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/sm83_microcode.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_microcode (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire sm83_pkg::decode_t  dec,
	input  wire sm83_pkg::m_cycle_t m_cycle,
	input  wire sm83_pkg::t_state_t t_state,
	output logic                    last_cycle,
	output sm83_pkg::mem_ctl_t      mem,
	output sm83_pkg::reg_ctl_t      regs,
	output sm83_pkg::adr_ctl_t      adr,
	output sm83_pkg::bus_ctl_t      bus,
	output sm83_pkg::alu_ctl_t      alu
);

	// Position decode
	logic m1, m2, m3, m4;
	logic t1, t2, t4;

	// Set by reset, cleared when the first instruction ends
	logic startup;

	sm83_pkg::instr_class_t cls;
	sm83_pkg::m_cycle_t     last_m;
	logic                   last_c;
	logic                   ldx;

	// Micro-operations, selected per M-cycle and expanded by T-state
	logic pc_adr;    // PC to address latch at T4
	logic reg_adr;   // Register pair to address latch at T4
	logic pc_inc;    // Latch+1 to PC at T1
	logic rd;
	logic wr;
	logic latch_wr;  // Data latch to register at T4
	logic src_rd;    // Register onto internal bus at T1
	logic st_latch;  // Internal bus into data latch at T1

	sm83_pkg::reg_pair_t adr_pair;
	sm83_pkg::reg_pair_t wr_pair;
	sm83_pkg::reg_pair_t rd_pair;
	logic                wr_hi;
	logic                rd_hi;

	// Strobes before reset gating
	sm83_pkg::mem_ctl_t mem_c;
	sm83_pkg::reg_ctl_t reg_c;
	sm83_pkg::adr_ctl_t adr_c;
	sm83_pkg::bus_ctl_t bus_c;
	sm83_pkg::alu_ctl_t alu_c;

	assign m1 = (m_cycle == sm83_pkg::M1);
	assign m2 = (m_cycle == sm83_pkg::M2);
	assign m3 = (m_cycle == sm83_pkg::M3);
	assign m4 = (m_cycle == sm83_pkg::M4);
	assign t1 = (t_state == sm83_pkg::T1);
	assign t2 = (t_state == sm83_pkg::T2);
	assign t4 = (t_state == sm83_pkg::T4);

	// First instruction after reset runs as NOP whatever IR holds
	assign cls = startup ? sm83_pkg::NOP : dec.cls;
	assign ldx = (cls == sm83_pkg::ST_NN_A) || (cls == sm83_pkg::LD_A_NN);

	always_ff @(posedge clk) begin
		if (reset) begin
			startup <= 1'b1;
		end else if (last_c) begin
			startup <= 1'b0;
		end
	end

	// Final M-cycle per class
	always_comb begin
		case (cls)
			sm83_pkg::LD_R_N,
			sm83_pkg::LD_R_HL,
			sm83_pkg::LD_HL_R,
			sm83_pkg::ST_XX_A,
			sm83_pkg::LD_A_XX: last_m = sm83_pkg::M2;
			sm83_pkg::LD_HL_N: last_m = sm83_pkg::M3;
			sm83_pkg::ST_NN_A,
			sm83_pkg::LD_A_NN: last_m = sm83_pkg::M4;
			default: last_m = sm83_pkg::M1;
		endcase
	end

	assign last_c = t4 && (m_cycle == last_m);

	// Micro-operation selection
	always_comb begin
		pc_adr   = 1'b0;
		reg_adr  = 1'b0;
		pc_inc   = 1'b0;
		rd       = 1'b0;
		wr       = 1'b0;
		latch_wr = 1'b0;
		src_rd   = 1'b0;
		st_latch = 1'b0;
		adr_pair = sm83_pkg::REG_HL;
		wr_pair  = dec.dst_pair;
		wr_hi    = dec.dst_hi;
		rd_pair  = dec.src_pair;
		rd_hi    = dec.src_hi;

		case (cls)
			sm83_pkg::LD_R_N: begin
				// Immediate read in M2
				pc_adr   = m1;
				rd       = m1;
				pc_inc   = m2;
				latch_wr = m2;
			end
			sm83_pkg::LD_HL_N: begin
				pc_adr  = m1;
				rd      = m1;
				pc_inc  = m2;
				// Immediate stays in the data latch for the M3 write
				reg_adr = m2;
				wr      = m2;
			end
			sm83_pkg::LD_R_R: begin
				src_rd = m1;
			end
			sm83_pkg::LD_R_HL: begin
				reg_adr  = m1;
				rd       = m1;
				latch_wr = m2;
			end
			sm83_pkg::LD_HL_R: begin
				reg_adr  = m1;
				wr       = m1;
				src_rd   = m2;
				st_latch = m2;
			end
			sm83_pkg::ST_XX_A: begin
				adr_pair = dec.ind_pair;
				reg_adr  = m1;
				wr       = m1;
				rd_pair  = sm83_pkg::REG_AF;
				rd_hi    = 1'b1;
				src_rd   = m2;
				st_latch = m2;
			end
			sm83_pkg::LD_A_XX: begin
				adr_pair = dec.ind_pair;
				reg_adr  = m1;
				rd       = m1;
				wr_pair  = sm83_pkg::REG_AF;
				wr_hi    = 1'b1;
				latch_wr = m2;
			end
			sm83_pkg::ST_NN_A,
			sm83_pkg::LD_A_NN: begin
				// Two immediate bytes in M2 and M3, data access in M4
				pc_adr   = m1 || m2;
				pc_inc   = m2 || m3;
				rd       = m1 || m2 || (m3 && cls == sm83_pkg::LD_A_NN);
				wr       = m3 && (cls == sm83_pkg::ST_NN_A);
				rd_pair  = sm83_pkg::REG_AF;
				rd_hi    = 1'b1;
				wr_pair  = sm83_pkg::REG_AF;
				wr_hi    = 1'b1;
				src_rd   = m4 && (cls == sm83_pkg::ST_NN_A);
				st_latch = m4 && (cls == sm83_pkg::ST_NN_A);
				latch_wr = m4 && (cls == sm83_pkg::LD_A_NN);
			end
			default: begin
				// NOP and unsupported, fetch only
				pc_adr = 1'b0;
			end
		endcase
	end

	// Expansion into strobes
	always_comb begin
		mem_c = '0;
		reg_c = '0;
		adr_c = '0;
		bus_c = '0;
		alu_c = '0;

		// Memory access of cycle k is requested at T4 of cycle k-1
		mem_c.mread  = rd && t4;
		mem_c.mwrite = wr && t4;

		if (pc_adr && t4) begin
			reg_c.pc_oe    = 1'b1;
			adr_c.al_hi_we = 1'b1;
			adr_c.al_lo_we = 1'b1;
		end
		if (reg_adr && t4) begin
			reg_c.sel      = adr_pair;
			reg_c.adr_oe   = 1'b1;
			adr_c.al_hi_we = 1'b1;
			adr_c.al_lo_we = 1'b1;
		end
		if (pc_inc && t1) begin
			reg_c.pc_we     = 1'b1;
			adr_c.inc_oe    = 1'b1;
			adr_c.inc_carry = 1'b1;
		end
		// Source byte crosses to the other half of the bus
		if (src_rd && t1) begin
			reg_c.sel       = rd_pair;
			reg_c.hi_oe     = rd_hi;
			reg_c.lo_oe     = ~rd_hi;
			bus_c.db_h2l_oe = rd_hi;
			bus_c.db_l2h_oe = ~rd_hi;
		end
		if (st_latch && t1) begin
			bus_c.db_l2c_oe  = 1'b1;
			bus_c.io_data_we = 1'b1;
		end
		if (latch_wr && t4) begin
			bus_c.io_data_oe = 1'b1;
			bus_c.db_c2l_oe  = 1'b1;
			bus_c.db_l2h_oe  = 1'b1;
			reg_c.hi_in      = 1'b1;
			reg_c.lo_in      = 1'b1;
			reg_c.sel        = wr_pair;
			reg_c.hi_we      = wr_hi;
			reg_c.lo_we      = ~wr_hi;
		end

		// LD r,r' goes through ALU operand A in one M-cycle
		if (cls == sm83_pkg::LD_R_R && m1) begin
			alu_c.sh_oe    = t1;
			alu_c.op_a_bus = t1;
			if (t2) begin
				alu_c.op_a_oe   = 1'b1;
				alu_c.oe        = 1'b1;
				bus_c.db_h2l_oe = 1'b1;
				reg_c.hi_in     = 1'b1;
				reg_c.lo_in     = 1'b1;
				reg_c.sel       = wr_pair;
				reg_c.hi_we     = wr_hi;
				reg_c.lo_we     = ~wr_hi;
			end
		end

		// LDX builds the address latch in M3
		if (ldx && m3) begin
			if (t1) begin
				// Low address byte parks in operand A
				bus_c.io_data_oe = 1'b1;
				bus_c.db_c2l_oe  = 1'b1;
				bus_c.db_l2h_oe  = 1'b1;
				alu_c.sh_oe      = 1'b1;
				alu_c.op_a_bus   = 1'b1;
			end
			if (t2) begin
				alu_c.op_a_oe   = 1'b1;
				alu_c.oe        = 1'b1;
				bus_c.db_h2l_oe = 1'b1;
				reg_c.hi_in     = 1'b1;
				reg_c.lo_in     = 1'b1;
				reg_c.adr_oe    = 1'b1;
				reg_c.sel       = dec.ind_pair;
				adr_c.al_lo_we  = 1'b1;
			end
			if (t4) begin
				// High byte straight from the data latch
				bus_c.io_data_oe = 1'b1;
				bus_c.db_c2l_oe  = 1'b1;
				bus_c.db_l2h_oe  = 1'b1;
				reg_c.hi_in      = 1'b1;
				reg_c.lo_in      = 1'b1;
				reg_c.adr_oe     = 1'b1;
				reg_c.sel        = dec.ind_pair;
				adr_c.al_hi_we   = 1'b1;
			end
		end

		// Opcode fetch request on the final T4
		if (last_c) begin
			mem_c.mread    = 1'b1;
			reg_c.pc_oe    = 1'b1;
			adr_c.al_hi_we = 1'b1;
			adr_c.al_lo_we = 1'b1;
		end
		if (m1 && t1) begin
			reg_c.pc_we     = 1'b1;
			adr_c.inc_oe    = 1'b1;
			// PC stays put on the very first fetch
			adr_c.inc_carry = ~startup;
		end
		if (m1 && t4) begin
			// zero opcode replaces the bus byte after reset
			bus_c.io_data_oe   = ~startup;
			bus_c.zero_data_oe = startup;
			bus_c.ir_we        = 1'b1;
			bus_c.ir_bank_we   = 1'b1;
			alu_c.cond_we      = 1'b1;
		end
	end

	// Everything quiet while reset is held
	assign last_cycle = last_c && !reset;
	assign mem        = reset ? '0 : mem_c;
	assign regs       = reset ? '0 : reg_c;
	assign adr        = reset ? '0 : adr_c;
	assign bus        = reset ? '0 : bus_c;
	assign alu        = reset ? '0 : alu_c;

endmodule

`default_nettype wire

// ==== rtl/sm83_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_control (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire sm83_pkg::word_t    opcode,
	output sm83_pkg::m_cycle_t      m_cycle,
	output sm83_pkg::t_state_t      t_state,
	output sm83_pkg::mem_ctl_t      mem,
	output sm83_pkg::reg_ctl_t      regs,
	output sm83_pkg::adr_ctl_t      adr,
	output sm83_pkg::bus_ctl_t      bus,
	output sm83_pkg::alu_ctl_t      alu
);

	// Decoded opcode
	sm83_pkg::decode_t dec;

	// End of instruction, back to the sequencer
	logic last_cycle;

	sm83_sequencer seq (
		.clk        (clk),
		.reset      (reset),
		.last_cycle (last_cycle),
		.m_cycle    (m_cycle),
		.t_state    (t_state)
	);

	sm83_decode decoder (
		.opcode (opcode),
		.dec    (dec)
	);

	sm83_microcode ucode (
		.clk        (clk),
		.reset      (reset),
		.dec        (dec),
		.m_cycle    (m_cycle),
		.t_state    (t_state),
		.last_cycle (last_cycle),
		.mem        (mem),
		.regs       (regs),
		.adr        (adr),
		.bus        (bus),
		.alu        (alu)
	);

endmodule

`default_nettype wire

// ==== bench/sm83_control_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_control_checker (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire sm83_pkg::m_cycle_t  m_cycle,
	input  wire sm83_pkg::t_state_t  t_state,
	input  wire sm83_pkg::mem_ctl_t  mem,
	input  wire sm83_pkg::reg_ctl_t  regs,
	input  wire sm83_pkg::adr_ctl_t  adr,
	input  wire sm83_pkg::bus_ctl_t  bus,
	input  wire sm83_pkg::alu_ctl_t  alu,
	input  wire sm83_pkg::word_t     exp_opcode,
	input  wire logic [31:0]         exp_cycles,
	input  wire logic [31:0]         exp_reads,
	input  wire logic [31:0]         exp_writes,
	input  wire logic                exp_has_wr,
	input  wire sm83_pkg::reg_pair_t exp_pair,
	input  wire logic                exp_hi,
	input  wire logic [31:0]         test_id,
	output int                       errors,
	output int                       passed,
	output int                       failed
);

	int err_total = 0;
	int pass_total = 0;
	int fail_total = 0;

	// Expectations latched at the window's M1 T1
	sm83_pkg::word_t     w_opcode;
	int                  w_cycles;
	int                  w_reads;
	int                  w_writes;
	logic                w_has_wr;
	sm83_pkg::reg_pair_t w_pair;
	logic                w_hi;
	int                  w_test;
	logic                w_ldx;

	// Window bookkeeping
	logic                win_open = 1'b0;
	int                  win_idx = 0;
	int                  win_err;
	int                  win_clocks;
	int                  rd_cnt;
	int                  wr_cnt;
	int                  we_cnt;
	sm83_pkg::reg_pair_t we_sel;
	logic                we_hi;
	// LDX address latch writes in M3
	int                  lo_only;
	int                  hi_only;
	int                  both_m3;

	assign errors = err_total;
	assign passed = pass_total;
	assign failed = fail_total;

	task automatic flag_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		err_total++;
		win_err++;
	endtask

	task automatic open_window;
		w_opcode   = exp_opcode;
		w_cycles   = exp_cycles;
		w_reads    = exp_reads;
		w_writes   = exp_writes;
		w_has_wr   = exp_has_wr;
		w_pair     = exp_pair;
		w_hi       = exp_hi;
		w_test     = (win_idx == 0) ? 0 : test_id;
		w_ldx      = (exp_opcode == 8'hEA) || (exp_opcode == 8'hFA);
		win_err    = 0;
		win_clocks = 0;
		rd_cnt     = 0;
		wr_cnt     = 0;
		we_cnt     = 0;
		lo_only    = 0;
		hi_only    = 0;
		both_m3    = 0;
		win_open   = 1'b1;
	endtask

	task automatic close_window;
		// Start-up window is a plain fetch whatever the opcode
		if (win_idx == 0) begin
			w_cycles = 1;
			w_reads  = 0;
			w_writes = 0;
			w_has_wr = 1'b0;
			w_ldx    = 1'b0;
		end
		if (win_clocks != 4 * w_cycles) begin
			flag_mismatch($sformatf("opcode %02h took %0d clocks, expected %0d",
				w_opcode, win_clocks, 4 * w_cycles));
		end
		// One extra read for the next fetch
		if (rd_cnt != w_reads + 1) begin
			flag_mismatch($sformatf("opcode %02h gave %0d mread, expected %0d",
				w_opcode, rd_cnt, w_reads + 1));
		end
		if (wr_cnt != w_writes) begin
			flag_mismatch($sformatf("opcode %02h gave %0d mwrite, expected %0d",
				w_opcode, wr_cnt, w_writes));
		end
		if (w_has_wr) begin
			if (we_cnt != 1) begin
				flag_mismatch($sformatf("opcode %02h gave %0d register writes, expected 1",
					w_opcode, we_cnt));
			end else if (we_sel != w_pair || we_hi != w_hi) begin
				flag_mismatch($sformatf("opcode %02h wrote pair %0d high %0b, expected %0d %0b",
					w_opcode, we_sel, we_hi, w_pair, w_hi));
			end
		end else if (we_cnt != 0) begin
			flag_mismatch($sformatf("opcode %02h wrote a register %0d times, expected none",
				w_opcode, we_cnt));
		end
		if (w_ldx && (lo_only == 0 || hi_only == 0 || both_m3 != 0)) begin
			flag_mismatch($sformatf("opcode %02h address latch halves not split in M3",
				w_opcode));
		end
		if (w_test != 0) begin
			if (win_err == 0) begin
				pass_total++;
				$display("test %0d opcode %02h ok", w_test, w_opcode);
			end else begin
				fail_total++;
				$display("test %0d opcode %02h bad, %0d errors", w_test, w_opcode, win_err);
			end
		end
		win_idx++;
	endtask

	task automatic sample_cycle;
		logic m1;
		m1 = (m_cycle == sm83_pkg::M1);
		win_clocks++;
		if (mem.mread) begin
			rd_cnt++;
		end
		if (mem.mwrite) begin
			wr_cnt++;
		end
		if ((mem.mread || mem.mwrite) && t_state != sm83_pkg::T4) begin
			flag_mismatch("memory strobe outside T4");
		end

		if (regs.hi_we || regs.lo_we) begin
			we_cnt++;
			we_sel = regs.sel;
			we_hi  = regs.hi_we;
			if (regs.hi_we && regs.lo_we) begin
				flag_mismatch("both register halves written at once");
			end
		end

		// Latch loads from PC, HL or the opcode's pair
		if (adr.al_hi_we || adr.al_lo_we) begin
			if (!(regs.pc_oe || (regs.adr_oe &&
				(regs.sel == sm83_pkg::REG_HL || regs.sel == w_opcode[5:4])))) begin
				flag_mismatch($sformatf("address latch from no valid source, sel %0d",
					regs.sel));
			end
		end
		if (w_ldx && m_cycle == sm83_pkg::M3) begin
			if (adr.al_lo_we && adr.al_hi_we) begin
				both_m3++;
			end else if (adr.al_lo_we) begin
				lo_only++;
			end else if (adr.al_hi_we) begin
				hi_only++;
			end
		end

		// Fetch sequence
		if (m1 && t_state == sm83_pkg::T1) begin
			if (!(regs.pc_we && adr.inc_oe)) begin
				flag_mismatch("pc_we or inc_oe missing in M1 T1");
			end
			if (adr.inc_carry != (win_idx != 0)) begin
				flag_mismatch($sformatf("inc_carry %0b in M1 T1 of window %0d",
					adr.inc_carry, win_idx));
			end
		end
		if (m1 && t_state == sm83_pkg::T4) begin
			if (!bus.ir_we) begin
				flag_mismatch("ir_we missing in M1 T4");
			end
			// Zero opcode only on the start-up fetch
			if (bus.zero_data_oe != (win_idx == 0) || bus.io_data_oe != (win_idx != 0)) begin
				flag_mismatch($sformatf("zero_data_oe %0b io_data_oe %0b in window %0d",
					bus.zero_data_oe, bus.io_data_oe, win_idx));
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			if (mem != '0 || regs != '0 || adr != '0 || bus != '0 || alu != '0) begin
				flag_mismatch("strobe active during reset");
			end
			win_open = 1'b0;
			win_idx  = 0;
		end else begin
			if (m_cycle == sm83_pkg::M1 && t_state == sm83_pkg::T1) begin
				if (win_open) begin
					close_window();
				end
				open_window();
			end
			if (win_open) begin
				sample_cycle();
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/sm83_control_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm83_control_tb;

	// Longest instruction is 16 clocks
	localparam int FETCH_TIMEOUT = 64;

	logic            clk = 1'b0;
	logic            reset;
	sm83_pkg::word_t opcode;

	sm83_pkg::m_cycle_t m_cycle;
	sm83_pkg::t_state_t t_state;
	sm83_pkg::mem_ctl_t mem;
	sm83_pkg::reg_ctl_t regs;
	sm83_pkg::adr_ctl_t adr;
	sm83_pkg::bus_ctl_t bus;
	sm83_pkg::alu_ctl_t alu;

	// Expected values for the instruction in flight
	sm83_pkg::word_t     exp_opcode;
	int                  exp_cycles;
	int                  exp_reads;
	int                  exp_writes;
	logic                exp_has_wr;
	sm83_pkg::reg_pair_t exp_pair;
	logic                exp_hi;
	int                  test_id;

	int errors;
	int passed;
	int failed;

	// Pattern file fields
	integer              fd;
	logic [8*96-1:0]     line;
	int                  fields;
	sm83_pkg::word_t     pat_opcode;
	int                  pat_cycles;
	int                  pat_reads;
	int                  pat_writes;
	int                  pat_pair;
	int                  pat_hi;

	integer seed;
	int     idle;
	int     n_tests;
	int     bad_lines;
	logic   timed_out;

	always #50 clk = ~clk;

	sm83_control UUT (
		.clk     (clk),
		.reset   (reset),
		.opcode  (opcode),
		.m_cycle (m_cycle),
		.t_state (t_state),
		.mem     (mem),
		.regs    (regs),
		.adr     (adr),
		.bus     (bus),
		.alu     (alu)
	);

	sm83_control_checker scoreboard (
		.clk        (clk),
		.reset      (reset),
		.m_cycle    (m_cycle),
		.t_state    (t_state),
		.mem        (mem),
		.regs       (regs),
		.adr        (adr),
		.bus        (bus),
		.alu        (alu),
		.exp_opcode (exp_opcode),
		.exp_cycles (exp_cycles),
		.exp_reads  (exp_reads),
		.exp_writes (exp_writes),
		.exp_has_wr (exp_has_wr),
		.exp_pair   (exp_pair),
		.exp_hi     (exp_hi),
		.test_id    (test_id),
		.errors     (errors),
		.passed     (passed),
		.failed     (failed)
	);

	// Next M1 T1, seen on a falling edge
	task automatic wait_fetch;
		int clocks;
		clocks = 0;
		@(negedge clk);
		while (!(m_cycle == sm83_pkg::M1 && t_state == sm83_pkg::T1) &&
			clocks < FETCH_TIMEOUT) begin
			@(negedge clk);
			clocks++;
		end
		if (!(m_cycle == sm83_pkg::M1 && t_state == sm83_pkg::T1)) begin
			$display("instruction never ended");
			timed_out = 1'b1;
		end
	endtask

	// Opcode and expectations change together in M1 T1
	task automatic issue_instruction(
		input sm83_pkg::word_t     op,
		input int                  cycles,
		input int                  reads,
		input int                  writes,
		input logic                has_wr,
		input sm83_pkg::reg_pair_t pair,
		input logic                hi,
		input int                  id
	);
		if (!timed_out) begin
			wait_fetch();
		end
		if (!timed_out) begin
			opcode     = op;
			exp_opcode = op;
			exp_cycles = cycles;
			exp_reads  = reads;
			exp_writes = writes;
			exp_has_wr = has_wr;
			exp_pair   = pair;
			exp_hi     = hi;
			test_id    = id;
		end
	endtask

	initial begin
		seed       = 19440;
		reset      = 1'b1;
		opcode     = 8'h00;
		exp_opcode = 8'h00;
		exp_cycles = 1;
		exp_reads  = 0;
		exp_writes = 0;
		exp_has_wr = 1'b0;
		exp_pair   = sm83_pkg::REG_BC;
		exp_hi     = 1'b0;
		test_id    = 0;
		n_tests    = 0;
		bad_lines  = 0;
		timed_out  = 1'b0;

		fd = $fopen("bench/control_patterns.txt", "r");
		if (fd == 0) begin
			$display("pattern file bench/control_patterns.txt could not be opened");
			bad_lines = 1;
		end

		repeat (16) @(negedge clk);
		reset = 1'b0;

		// Start-up window passes first, then one pattern per line
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			line = '0;
			if ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %d %d %d %d %d", pat_opcode, pat_cycles,
					pat_reads, pat_writes, pat_pair, pat_hi);
				if (fields == 4 || fields == 6) begin
					// Random idle gap of extra NOPs
					idle = $unsigned($random(seed)) % 3;
					repeat (idle) begin
						issue_instruction(8'h00, 1, 0, 0, 1'b0, sm83_pkg::REG_BC, 1'b0, 0);
					end
					n_tests++;
					issue_instruction(pat_opcode, pat_cycles, pat_reads, pat_writes,
						fields == 6, sm83_pkg::reg_pair_t'(pat_pair), pat_hi != 0, n_tests);
				end else if (fields > 0) begin
					$display("pattern file line could not be read");
					bad_lines++;
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		// A trailing NOP closes the last window
		issue_instruction(8'h00, 1, 0, 0, 1'b0, sm83_pkg::REG_BC, 1'b0, 0);
		@(posedge clk);
		@(negedge clk);

		$display("%0d tests, %0d passed, %0d failed, %0d mismatches",
			n_tests, passed, failed, errors);
		if (!timed_out && bad_lines == 0 && errors == 0 && failed == 0 &&
			n_tests > 0 && passed == n_tests) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sm83_control.f ====
rtl/sm83_pkg.sv
rtl/sm83_sequencer.sv
rtl/sm83_decode.sv
rtl/sm83_microcode.sv
rtl/sm83_control.sv
bench/sm83_control_checker.sv
bench/sm83_control_tb.sv

// ==== Bender.yml ====
package:
  name: sm83_control

sources:
  - rtl/sm83_pkg.sv
  - rtl/sm83_sequencer.sv
  - rtl/sm83_decode.sv
  - rtl/sm83_microcode.sv
  - rtl/sm83_control.sv
  - target: simulation
    files:
      - bench/sm83_control_checker.sv
      - bench/sm83_control_tb.sv

// ==== bench/control_patterns.txt ====
# opcode  m-cycles  data-reads  data-writes  write-pair  write-high
# last two columns are replaced by none when no register is written
00 1 0 0 none
3E 2 1 0 3 1
06 2 1 0 0 1
0E 2 1 0 0 0
36 3 1 1 none
41 1 0 0 0 1
5A 1 0 0 1 0
7C 1 0 0 3 1
46 2 1 0 0 1
6E 2 1 0 2 0
70 2 0 1 none
77 2 0 1 none
02 2 0 1 none
12 2 0 1 none
0A 2 1 0 3 1
1A 2 1 0 3 1
EA 4 2 1 none
FA 4 3 0 3 1
76 1 0 0 none
D3 1 0 0 none
